// ==== design/gesture_pkg.sv ====
// Shared register map, FSM states and reset values for the gesture detector
// Register offsets are word indices taken from HADDR[7:2]
package gesture_pkg;

    // AHB register word offsets
    typedef enum logic [5:0] {
        REG_RESULT    = 6'd0,
        REG_MODE      = 6'd1,
        REG_RGB_THR   = 6'd2,
        REG_CRCB_WIN  = 6'd3,
        REG_FRAME_CNT = 6'd4
    } reg_addr_e;

    // Frame sequencing states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COLLECT,
        ST_CLASSIFY,
        ST_REPORT
    } fsm_state_e;

    // Pixel word, Y/Cb/Cr or R/G/B from high byte to low byte
    localparam int PIX_W = 24;

    // Completed-frame counter, wraps at 256
    localparam int FRAME_CNT_W = 8;

    // One bit per quadrant
    localparam int GESTURE_W = 4;

    localparam logic [7:0] RGB_THR_RESET = 8'd70;

    // Cr max, Cr min, Cb max, Cb min from high byte to low byte
    localparam logic [31:0] CRCB_WIN_RESET = 32'hFF00_FF00;

endpackage

// ==== design/gesture_regs.sv ====
// AHB-Lite register slave, zero wait states and always OKAY
// HSIZE and HPROT are ignored, every access is treated as a 32-bit word
`timescale 1ns/1ps

module gesture_regs
    import gesture_pkg::*;
(
    input  logic                   HCLK,
    input  logic                   HRESETn,
    input  logic                   HSEL,
    input  logic [31:0]            HADDR,
    input  logic [1:0]             HTRANS,
    input  logic [2:0]             HSIZE,
    input  logic [3:0]             HPROT,
    input  logic                   HWRITE,
    input  logic [31:0]            HWDATA,
    input  logic                   HREADY,
    input  logic [GESTURE_W-1:0]   gesture,
    input  logic                   result_valid,
    input  logic [FRAME_CNT_W-1:0] frame_count,
    output logic                   HREADYOUT,
    output logic [31:0]            HRDATA,
    output logic                   HRESP,
    output logic                   bin_mode,
    output logic [7:0]             rgb_thr,
    output logic [31:0]            crcb_win
);

    logic                 accept;
    reg_addr_e            addr_q;
    logic                 write_q;
    logic [GESTURE_W-1:0] result_q;

    assign HREADYOUT = 1'b1;                              // No wait states
    assign HRESP     = 1'b0;                              // Always OKAY

    // NONSEQ or SEQ with the bus ready
    assign accept = HSEL & HTRANS[1] & HREADY;

    // Address phase capture
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            addr_q  <= REG_RESULT;
            write_q <= 1'b0;
        end else begin
            write_q <= accept & HWRITE;                   // One-cycle data phase
            if (accept) begin
                addr_q <= reg_addr_e'(HADDR[7:2]);
            end
        end
    end

    // Control registers, written at the end of the data phase
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            bin_mode <= 1'b0;
            rgb_thr  <= RGB_THR_RESET;
            crcb_win <= CRCB_WIN_RESET;
        end else if (write_q) begin
            case (addr_q)
                REG_MODE:     bin_mode <= HWDATA[0];
                REG_RGB_THR:  rgb_thr  <= HWDATA[7:0];
                REG_CRCB_WIN: crcb_win <= HWDATA;
                default: ;                                // RO and unmapped
            endcase
        end
    end

    // Gesture latched when the FSM reports
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            result_q <= '0;
        end else if (result_valid) begin
            result_q <= gesture;
        end
    end

    // Read data from the captured offset
    always_comb begin
        case (addr_q)
            REG_RESULT:    HRDATA = {{(32-GESTURE_W){1'b0}}, result_q};
            REG_MODE:      HRDATA = {31'b0, bin_mode};
            REG_RGB_THR:   HRDATA = {24'b0, rgb_thr};
            REG_CRCB_WIN:  HRDATA = crcb_win;
            REG_FRAME_CNT: HRDATA = {{(32-FRAME_CNT_W){1'b0}}, frame_count};
            default:       HRDATA = 32'b0;
        endcase
    end

    // Whatever the classifier hands over must stay a valid gesture code
    a_result_onehot0: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        $onehot0(result_q)
    );

endmodule

// ==== design/pixel_binarizer.sv ====
// Foreground decision per pixel with one cycle of latency
// Mode 0 tests Cb and Cr windows, mode 1 tests the red byte
`timescale 1ns/1ps

module pixel_binarizer
    import gesture_pkg::*;
(
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic             pix_valid,
    input  logic [PIX_W-1:0] pix_data,
    input  logic             bin_mode,
    input  logic [7:0]       rgb_thr,
    input  logic [31:0]      crcb_win,
    output logic             bin_valid,
    output logic             bin_fg
);

    logic [7:0] red;
    logic [7:0] cb;
    logic [7:0] cr;
    logic       cb_in;
    logic       cr_in;
    logic       fg;

    assign red = pix_data[23:16];                         // R in RGB mode
    assign cb  = pix_data[15:8];
    assign cr  = pix_data[7:0];

    // Inclusive window bounds
    assign cb_in = (cb >= crcb_win[7:0])   && (cb <= crcb_win[15:8]);
    assign cr_in = (cr >= crcb_win[23:16]) && (cr <= crcb_win[31:24]);

    assign fg = bin_mode ? (red >= rgb_thr) : (cb_in && cr_in);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            bin_valid <= 1'b0;
            bin_fg    <= 1'b0;
        end else begin
            bin_valid <= pix_valid;
            bin_fg    <= fg;
        end
    end

endmodule

// ==== design/pixel_counter.sv ====
// Raster position and completed-frame counter
// clear resets the position only, frame_count runs on across frame_sync
`timescale 1ns/1ps

module pixel_counter
    import gesture_pkg::*;
#(
    parameter int FRAME_W = 16,
    parameter int FRAME_H = 12
) (
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  logic                       clear,
    input  logic                       bin_valid,
    output logic [$clog2(FRAME_W)-1:0] pix_x,
    output logic [$clog2(FRAME_H)-1:0] pix_y,
    output logic                       frame_done,
    output logic [FRAME_CNT_W-1:0]     frame_count
);

    localparam int X_W = $clog2(FRAME_W);
    localparam int Y_W = $clog2(FRAME_H);
    localparam logic [X_W-1:0] X_LAST = X_W'(FRAME_W - 1);
    localparam logic [Y_W-1:0] Y_LAST = Y_W'(FRAME_H - 1);

    logic last_x;
    logic last_y;

    assign last_x = (pix_x == X_LAST);
    assign last_y = (pix_y == Y_LAST);

    // A pixel landing together with clear belongs to the aborted frame
    assign frame_done = bin_valid & last_x & last_y & ~clear;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pix_x <= '0;
            pix_y <= '0;
        end else if (clear) begin
            pix_x <= '0;
            pix_y <= '0;
        end else if (bin_valid) begin
            if (last_x) begin
                pix_x <= '0;
                pix_y <= last_y ? '0 : pix_y + 1'b1;     // Wrap at frame end
            end else begin
                pix_x <= pix_x + 1'b1;
            end
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            frame_count <= '0;
        end else if (frame_done) begin
            frame_count <= frame_count + 1'b1;            // Modulo 256
        end
    end

    a_x_in_range: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        pix_x <= X_LAST
    );

endmodule

// ==== design/frame_fsm.sv ====
// Frame sequencer, IDLE -> COLLECT -> CLASSIFY -> REPORT -> IDLE
// frame_sync restarts collection from any state
`timescale 1ns/1ps

module frame_fsm
    import gesture_pkg::*;
(
    input  logic HCLK,
    input  logic HRESETn,
    input  logic frame_sync,
    input  logic frame_done,
    output logic clear,
    output logic classify,
    output logic result_valid
);

    fsm_state_e state;
    fsm_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE:     state_nxt = ST_IDLE;
            ST_COLLECT:  if (frame_done) state_nxt = ST_CLASSIFY;
            ST_CLASSIFY: state_nxt = ST_REPORT;           // One cycle for argmax
            ST_REPORT:   state_nxt = ST_IDLE;
            default:     state_nxt = ST_IDLE;
        endcase
        if (frame_sync) begin
            state_nxt = ST_COLLECT;                       // Aborts a partial frame
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Same cycle as frame_sync, so the first pixel after it is counted
    assign clear        = frame_sync;
    assign classify     = (state == ST_CLASSIFY);
    assign result_valid = (state == ST_REPORT);

    a_single_report: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        result_valid |=> !result_valid
    );

endmodule

// ==== design/quadrant_classifier.sv ====
// Foreground counts per quadrant and argmax to a one-hot gesture
// Ties go to the lower quadrant index, an empty frame gives zero
`timescale 1ns/1ps

module quadrant_classifier
    import gesture_pkg::*;
#(
    parameter int FRAME_W = 16,
    parameter int FRAME_H = 12
) (
    input  logic                       HCLK,
    input  logic                       HRESETn,
    input  logic                       clear,
    input  logic                       classify,
    input  logic                       bin_valid,
    input  logic                       bin_fg,
    input  logic [$clog2(FRAME_W)-1:0] pix_x,
    input  logic [$clog2(FRAME_H)-1:0] pix_y,
    output logic [GESTURE_W-1:0]       gesture
);

    localparam int X_W   = $clog2(FRAME_W);
    localparam int Y_W   = $clog2(FRAME_H);
    localparam int CNT_W = $clog2(FRAME_W * FRAME_H / 4 + 1);  // Holds a full quadrant
    localparam logic [X_W-1:0] X_HALF = X_W'(FRAME_W / 2);
    localparam logic [Y_W-1:0] Y_HALF = Y_W'(FRAME_H / 2);

    logic [CNT_W-1:0]     acc [GESTURE_W];
    logic [1:0]           quad;
    logic [1:0]           best_idx;
    logic [CNT_W-1:0]     best_cnt;
    logic [GESTURE_W-1:0] gesture_nxt;

    // Bit 1 bottom half, bit 0 right half
    assign quad = {pix_y >= Y_HALF, pix_x >= X_HALF};

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            for (int i = 0; i < GESTURE_W; i++) begin
                acc[i] <= '0;
            end
        end else if (clear) begin
            for (int i = 0; i < GESTURE_W; i++) begin
                acc[i] <= '0;
            end
        end else if (bin_valid && bin_fg) begin
            acc[quad] <= acc[quad] + 1'b1;
        end
    end

    // Strict compare keeps the lower index on a tie
    always_comb begin
        best_idx = 2'd0;
        best_cnt = acc[0];
        for (int i = 1; i < GESTURE_W; i++) begin
            if (acc[i] > best_cnt) begin
                best_idx = 2'(i);
                best_cnt = acc[i];
            end
        end
    end

    assign gesture_nxt = (best_cnt == '0) ? '0 : (GESTURE_W'(1) << best_idx);

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            gesture <= '0;
        end else if (classify) begin
            gesture <= gesture_nxt;                       // Held until next frame
        end
    end

    a_gesture_onehot0: assert property (
        @(posedge HCLK) disable iff (!HRESETn)
        classify |=> $onehot0(gesture)
    );

endmodule

// ==== design/gesture_top.sv ====
// Gesture detector with AHB-Lite registers, single HCLK domain
// FRAME_W and FRAME_H must be even, pixels arrive already synchronous
`timescale 1ns/1ps

module gesture_top
    import gesture_pkg::*;
#(
    parameter int FRAME_W = 16,
    parameter int FRAME_H = 12
) (
    input  logic             HCLK,
    input  logic             HRESETn,
    input  logic             HSEL,
    input  logic [31:0]      HADDR,
    input  logic [1:0]       HTRANS,
    input  logic [2:0]       HSIZE,
    input  logic [3:0]       HPROT,
    input  logic             HWRITE,
    input  logic [31:0]      HWDATA,
    input  logic             HREADY,
    output logic             HREADYOUT,
    output logic [31:0]      HRDATA,
    output logic             HRESP,
    input  logic             frame_sync,
    input  logic             pix_valid,
    input  logic [PIX_W-1:0] pix_data,
    output logic             result_valid
);

    logic                       bin_mode;
    logic [7:0]                 rgb_thr;
    logic [31:0]                crcb_win;
    logic                       bin_valid;
    logic                       bin_fg;
    logic [$clog2(FRAME_W)-1:0] pix_x;
    logic [$clog2(FRAME_H)-1:0] pix_y;
    logic                       frame_done;
    logic [FRAME_CNT_W-1:0]     frame_count;
    logic                       clear;
    logic                       classify;
    logic [GESTURE_W-1:0]       gesture;

    gesture_regs u_regs (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .HSEL         (HSEL),
        .HADDR        (HADDR),
        .HTRANS       (HTRANS),
        .HSIZE        (HSIZE),
        .HPROT        (HPROT),
        .HWRITE       (HWRITE),
        .HWDATA       (HWDATA),
        .HREADY       (HREADY),
        .gesture      (gesture),
        .result_valid (result_valid),
        .frame_count  (frame_count),
        .HREADYOUT    (HREADYOUT),
        .HRDATA       (HRDATA),
        .HRESP        (HRESP),
        .bin_mode     (bin_mode),
        .rgb_thr      (rgb_thr),
        .crcb_win     (crcb_win)
    );

    pixel_binarizer u_binarizer (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .pix_valid (pix_valid),
        .pix_data  (pix_data),
        .bin_mode  (bin_mode),
        .rgb_thr   (rgb_thr),
        .crcb_win  (crcb_win),
        .bin_valid (bin_valid),
        .bin_fg    (bin_fg)
    );

    pixel_counter #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_counter (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .clear       (clear),
        .bin_valid   (bin_valid),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .frame_done  (frame_done),
        .frame_count (frame_count)
    );

    frame_fsm u_fsm (
        .HCLK         (HCLK),
        .HRESETn      (HRESETn),
        .frame_sync   (frame_sync),
        .frame_done   (frame_done),
        .clear        (clear),
        .classify     (classify),
        .result_valid (result_valid)
    );

    quadrant_classifier #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_classifier (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .clear     (clear),
        .classify  (classify),
        .bin_valid (bin_valid),
        .bin_fg    (bin_fg),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .gesture   (gesture)
    );

endmodule

// ==== sim/tb_gesture_tasks.svh ====
// Bus and pixel stream drivers that change every input on the falling edge
// Single AHB transfers only with register offsets as word indices

task automatic ahb_write(input logic [5:0] idx, input logic [31:0] data);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = {24'b0, idx, 2'b00};
    HTRANS = 2'b10;                                       // NONSEQ
    HWRITE = 1'b1;
    @(negedge HCLK);
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    HWDATA = data;                                        // Data phase
endtask

task automatic ahb_read(input logic [5:0] idx, output logic [31:0] data);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = {24'b0, idx, 2'b00};
    HTRANS = 2'b10;
    HWRITE = 1'b0;
    @(negedge HCLK);
    HSEL   = 1'b0;
    HTRANS = 2'b00;
    data   = HRDATA;                                      // Middle of the data phase
endtask

// Frame sync pulse, then the first npix pixels of frame_buf with random idle gaps
task automatic send_frame(input int npix, input int max_gap);
    @(negedge HCLK);
    frame_sync = 1'b1;
    @(negedge HCLK);
    frame_sync = 1'b0;
    for (int i = 0; i < npix; i++) begin
        repeat ($urandom % (max_gap + 1)) @(negedge HCLK);
        pix_valid      = 1'b1;
        pix_data       = frame_buf[i];
        last_pix_cycle = cycle_cnt;
        @(negedge HCLK);
        pix_valid = 1'b0;
    end
endtask

// Quadrant dom gets about 3/4 foreground and the others 1/4 (none when dom is 4)
task automatic fill_frame(input logic mode, input int dom);
    int         q;
    int         thr_i;
    logic       fg;
    logic [7:0] hi;
    logic [7:0] cb;
    logic [7:0] cr;
    thr_i = int'(cur_thr);
    for (int y = 0; y < FRAME_H; y++) begin
        for (int x = 0; x < FRAME_W; x++) begin
            q  = ((y >= FRAME_H / 2) ? 2 : 0) + ((x >= FRAME_W / 2) ? 1 : 0);
            fg = (dom < 4) && (($urandom % 4) < ((q == dom) ? 3 : 1));
            if (mode) begin
                hi = fg ? 8'(thr_i + $urandom % (256 - thr_i)) : 8'($urandom % thr_i);
                frame_buf[y * FRAME_W + x] = {hi, 16'($urandom)};
            end else begin
                cb = fg ? 8'(cb_min + $urandom % 9) : 8'($urandom % cb_min);  // Below window
                cr = fg ? 8'(cr_min + $urandom % 9) : 8'($urandom);
                frame_buf[y * FRAME_W + x] = {8'($urandom), cb, cr};
            end
        end
    end
endtask

// ==== sim/tb_gesture_top.sv ====
// Self-checking testbench for gesture_top with the default 16x12 frame
// Expected gestures come from a behavioral model of the binarizer and argmax rules
`timescale 1ns/1ps

module tb_gesture_top
    import gesture_pkg::*;
();

    localparam int FRAME_W     = 16;
    localparam int FRAME_H     = 12;
    localparam int NPIX        = FRAME_W * FRAME_H;
    localparam int N_RGB       = 6;
    localparam int PARTIAL_PIX = 80;                      // Five rows in the top half
    localparam int TOTAL_PIX   = (N_RGB + 7) * NPIX + PARTIAL_PIX;
    localparam int CYCLE_LIMIT = 20 * TOTAL_PIX + 2000;
    localparam int RESULT_LAT  = 3;                       // Last pixel to result_valid

    logic             HCLK;
    logic             HRESETn;
    logic             HSEL;
    logic [31:0]      HADDR;
    logic [1:0]       HTRANS;
    logic [2:0]       HSIZE;
    logic [3:0]       HPROT;
    logic             HWRITE;
    logic [31:0]      HWDATA;
    logic             HREADY;
    logic             HREADYOUT;
    logic [31:0]      HRDATA;
    logic             HRESP;
    logic             frame_sync;
    logic             pix_valid;
    logic [PIX_W-1:0] pix_data;
    logic             result_valid;

    logic [PIX_W-1:0] frame_buf [NPIX];
    logic             cur_mode;
    logic [7:0]       cur_thr;
    logic [31:0]      cur_win;
    int               cb_min;
    int               cr_min;
    string            cur_test;
    logic [3:0]       exp_gesture;
    logic [7:0]       exp_frames;
    logic [31:0]      rd_result;
    logic [31:0]      rd_count;
    logic [31:0]      wr;
    int               checks_done;
    int               pass_cnt;
    int               fail_cnt;
    int               cycle_cnt;
    int               last_pix_cycle;

    `include "tb_gesture_tasks.svh"

    gesture_top DUT (.*);

    // Largest foreground count wins and ties go to the lower index
    function automatic logic [3:0] expected_gesture(input logic [PIX_W-1:0] frm [NPIX],
                                                    input logic mode, input logic [7:0] thr,
                                                    input logic [31:0] win);
        int         cnt [4];
        int         best;
        int         q;
        logic       fg;
        logic [7:0] cb;
        logic [7:0] cr;
        for (int i = 0; i < 4; i++) begin
            cnt[i] = 0;
        end
        for (int i = 0; i < NPIX; i++) begin
            cb = frm[i][15:8];
            cr = frm[i][7:0];
            if (mode) begin
                fg = (frm[i][23:16] >= thr);
            end else begin
                fg = (cb >= win[7:0]) && (cb <= win[15:8]) &&
                     (cr >= win[23:16]) && (cr <= win[31:24]);
            end
            q = ((i / FRAME_W >= FRAME_H / 2) ? 2 : 0) + ((i % FRAME_W >= FRAME_W / 2) ? 1 : 0);
            if (fg) begin
                cnt[q]++;
            end
        end
        best = 0;
        for (int i = 1; i < 4; i++) begin
            if (cnt[i] > cnt[best]) begin
                best = i;
            end
        end
        return (cnt[best] == 0) ? 4'b0000 : (4'b0001 << best);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail %s expected 0x%0h actual 0x%0h", name, exp, act);
            fail_cnt++;
        end else begin
            $display("Pass %s value 0x%0h", name, act);
            pass_cnt++;
        end
    endtask

    task automatic read_check(input logic [5:0] idx, input string name, input logic [31:0] exp);
        logic [31:0] rd;
        ahb_read(idx, rd);
        check_value(name, exp, rd);
        if (HREADYOUT !== 1'b1 || HRESP !== 1'b0) begin
            $display("Fail %s_resp expected HREADYOUT 1 HRESP 0 actual HREADYOUT %b HRESP %b",
                     name, HREADYOUT, HRESP);
            fail_cnt++;
        end
    endtask

    // Sends one full frame and waits until the compare process has checked it
    task automatic run_frame(input string name, input logic [3:0] expected, input int max_gap);
        int target;
        cur_test    = name;
        exp_gesture = expected;
        exp_frames  = exp_frames + 8'd1;
        target      = checks_done + 1;
        send_frame(NPIX, max_gap);
        wait (checks_done >= target);
    endtask

    initial begin : clock_gen
        HCLK = 1'b0;
        forever begin
            #2 HCLK = ~HCLK;                              // 4 ns period
        end
    end

    initial begin : cycle_limit
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge HCLK);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    // Result register holds the new gesture from the cycle after result_valid
    initial begin : compare_results
        forever begin
            @(negedge HCLK);
            if (result_valid === 1'b1) begin
                check_value($sformatf("%s_latency", cur_test), RESULT_LAT,
                            32'(cycle_cnt - last_pix_cycle));
                ahb_read(REG_RESULT, rd_result);
                ahb_read(REG_FRAME_CNT, rd_count);
                check_value($sformatf("%s_gesture", cur_test), {28'b0, exp_gesture}, rd_result);
                check_value($sformatf("%s_frame_count", cur_test), {24'b0, exp_frames}, rd_count);
                checks_done++;
            end
        end
    end

    initial begin : main_sequence
        HRESETn        = 1'b0;
        HSEL           = 1'b0;
        HADDR          = 32'b0;
        HTRANS         = 2'b00;
        HSIZE          = 3'b010;                          // Word
        HPROT          = 4'b0011;
        HWRITE         = 1'b0;
        HWDATA         = 32'b0;
        HREADY         = 1'b1;
        frame_sync     = 1'b0;
        pix_valid      = 1'b0;
        pix_data       = '0;
        checks_done    = 0;
        pass_cnt       = 0;
        fail_cnt       = 0;
        last_pix_cycle = 0;
        exp_frames     = 8'd0;
        cur_test       = "none";
        void'($urandom(32'h47f862b8));
        repeat (3) @(posedge HCLK);
        @(negedge HCLK);
        HRESETn = 1'b1;

        read_check(REG_RESULT, "reset_result", 32'd0);
        read_check(REG_MODE, "reset_mode", 32'd0);
        read_check(REG_RGB_THR, "reset_rgb_thr", 32'd70);
        read_check(REG_CRCB_WIN, "reset_crcb_win", 32'hFF00_FF00);
        read_check(REG_FRAME_CNT, "reset_frame_cnt", 32'd0);
        read_check(6'd9, "reset_unmapped", 32'd0);

        wr = $urandom;
        ahb_write(REG_MODE, wr);
        read_check(REG_MODE, "regs_mode", {31'b0, wr[0]});
        cur_mode = wr[0];
        wr = $urandom;
        ahb_write(REG_RGB_THR, wr);
        read_check(REG_RGB_THR, "regs_rgb_thr", {24'b0, wr[7:0]});
        cur_thr = wr[7:0];
        wr = $urandom;
        ahb_write(REG_CRCB_WIN, wr);
        read_check(REG_CRCB_WIN, "regs_crcb_win", wr);
        cur_win = wr;
        ahb_write(REG_RESULT, 32'hFFFF_FFFF);
        ahb_write(6'd9, 32'hFFFF_FFFF);
        read_check(REG_RESULT, "regs_result_ro", 32'd0);
        read_check(6'd9, "regs_unmapped", 32'd0);
        read_check(REG_MODE, "regs_mode_kept", {31'b0, cur_mode});
        read_check(REG_RGB_THR, "regs_rgb_thr_kept", {24'b0, cur_thr});
        read_check(REG_CRCB_WIN, "regs_crcb_win_kept", cur_win);

        ahb_write(REG_MODE, 32'd1);
        for (int f = 0; f < N_RGB; f++) begin
            cur_thr = 8'(1 + $urandom % 255);
            ahb_write(REG_RGB_THR, {24'b0, cur_thr});
            fill_frame(1'b1, $urandom % 4);
            run_frame($sformatf("rgb_frame%0d", f),
                      expected_gesture(frame_buf, 1'b1, cur_thr, cur_win), 3);
        end

        ahb_write(REG_MODE, 32'd0);
        cb_min  = 16 + $urandom % 200;
        cr_min  = 16 + $urandom % 200;
        cur_win = {8'(cr_min + 8), 8'(cr_min), 8'(cb_min + 8), 8'(cb_min)};  // Nine codes wide
        ahb_write(REG_CRCB_WIN, cur_win);
        for (int d = 0; d < 4; d++) begin
            fill_frame(1'b0, d);
            run_frame($sformatf("skin_q%0d", d),
                      expected_gesture(frame_buf, 1'b0, cur_thr, cur_win), 2);
        end
        fill_frame(1'b0, 4);
        run_frame("skin_empty", 4'b0000, 2);

        cur_thr = 8'd128;
        ahb_write(REG_MODE, 32'd1);
        ahb_write(REG_RGB_THR, 32'd128);
        for (int i = 0; i < NPIX; i++) begin
            frame_buf[i] = 24'hFF_0000;                   // All foreground but only top rows sent
        end
        send_frame(PARTIAL_PIX, 1);
        fill_frame(1'b1, 3);
        run_frame("abort_full", expected_gesture(frame_buf, 1'b1, cur_thr, cur_win), 1);
        // Even rows of the right half give 24 pixels in q1 and in q3
        for (int i = 0; i < NPIX; i++) begin
            frame_buf[i] = ((i % FRAME_W >= FRAME_W / 2) && ((i / FRAME_W) % 2 == 0)) ?
                           24'hFF_0000 : 24'h00_0000;
        end
        run_frame("tie_q1_q3", 4'b0010, 1);

        $display("Summary: %0d checks passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+sim
design/gesture_pkg.sv
design/gesture_regs.sv
design/pixel_binarizer.sv
design/pixel_counter.sv
design/frame_fsm.sv
design/quadrant_classifier.sv
design/gesture_top.sv
sim/tb_gesture_top.sv

// ==== Bender.yml ====
package:
  name: gesture_detector

sources:
  - files:
      - design/gesture_pkg.sv
      - design/gesture_regs.sv
      - design/pixel_binarizer.sv
      - design/pixel_counter.sv
      - design/frame_fsm.sv
      - design/quadrant_classifier.sv
      - design/gesture_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_gesture_top.sv
